/* build.f */
+incdir+sim
verilog/hid_cmd_pkg.sv
verilog/hid_io_pkg.sv
verilog/hid_cmd_fsm.sv
verilog/mouse_step_timer.sv
verilog/mouse_quadrature.sv
verilog/keyboard_matrix.sv
verilog/joystick_port.sv
verilog/hid_top.sv
sim/hid_tb.sv

/* sim/hid_tb_tasks.svh */
/*
  Link send tasks, LFSR stimulus and result counters for hid_tb.
  Tasks are called on a falling clock edge and return on one.
*/
`ifndef HID_TB_TASKS_SVH
`define HID_TB_TASKS_SVH

  logic [31:0] lfsr;
  int          errors;
  int          tests;
  int          test_base;

  // galois step, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [7:0] v);
    v = 8'd0;
    for (int i = 0; i < n; i++) begin
      v = {v[6:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // forward quadrature order 00 01 11 10
  function automatic logic [1:0] phase_fwd(input logic [1:0] q);
    case (q)
      2'b00: return 2'b01;
      2'b01: return 2'b11;
      2'b11: return 2'b10;
      default: return 2'b00;
    endcase
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("Mismatch at %0t: %s", $time, msg);
  endtask

  task automatic end_test(input string name);
    $display("test %-9s done, %0d errors", name, errors - test_base);
    tests++;
    test_base = errors;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  // one strobe cycle, then three quiet cycles
  task automatic send_byte(input logic start, input logic [7:0] d);
    data_in_strobe = 1'b1;
    data_in_start  = start;
    data_in        = d;
    @(negedge clk);
    data_in_strobe = 1'b0;
    data_in_start  = 1'b0;
    idle(3);
  endtask

  task automatic check_dout(input logic [7:0] v);
    exp_dout = v;
    chk_dout = 1'b1;
    idle(2);
    chk_dout = 1'b0;
  endtask

  task automatic scan_matrix();
    logic [7:0] v;
    for (int i = 0; i < 8; i++) begin
      matrix_out = ~(8'd1 << i);
      @(negedge clk);
    end
    for (int i = 0; i < 8; i++) begin
      rand_bits(8, v);
      matrix_out = v;
      @(negedge clk);
    end
    matrix_out = 8'hff;
  endtask

  task automatic joy_packet(input logic [7:0] dev);
    logic [7:0] d;
    rand_bits(8, d);
    chk_joy = 1'b0;
    send_byte(1'b1, hid_cmd_pkg::cmd_joystick);
    send_byte(1'b0, dev);
    send_byte(1'b0, d);
    case (dev)
      8'h00: exp_j0 = d;
      8'h01: exp_j1 = d;
      8'h80: exp_np = d;
      default: ;
    endcase
    chk_joy = 1'b1;
    idle(2);
  endtask

  task automatic wait_irq(input int limit);
    int n;
    n = 0;
    while (!irq && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!irq) begin
      errors++;
      $display("Timeout: irq still low %0d cycles after the DB9 change", limit);
    end
  endtask

  task automatic wait_quad(input int limit);
    int n;
    n = 0;
    while ((x_fwd < 3 || y_back < 2) && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (x_fwd < 3 || y_back < 2) begin
      errors++;
      $display("Timeout: mouse phases incomplete after %0d cycles", limit);
    end
  endtask

`endif

/* sim/hid_tb.sv */
/*
  Testbench for hid_top. Concurrent assertions do the checking and are
  enabled by flags from the test sequence. The mouse test runs ~100k cycles.
*/
`timescale 1ns/100ps
`default_nettype none

module hid_tb;

  logic       clk;
  logic       reset;
  logic       data_in_strobe;
  logic       data_in_start;
  logic [7:0] data_in;
  wire  [7:0] data_out;
  logic [5:0] db9_port;
  logic       iack;
  wire        irq;
  wire  [7:0] joystick0;
  wire  [7:0] joystick1;
  wire  [7:0] numpad;
  logic [7:0] matrix_out;
  wire  [7:0] matrix_in;
  wire  [1:0] mouse_btns;
  wire        mouse_strobe;
  wire  [1:0] mouse_x_quad;
  wire  [1:0] mouse_y_quad;

  // check enables and expected values
  logic       chk_dout;
  logic [7:0] exp_dout;
  logic       chk_key;
  logic       key_down;
  logic [2:0] key_row;
  logic [2:0] key_col;
  logic       chk_joy;
  logic [7:0] exp_j0;
  logic [7:0] exp_j1;
  logic [7:0] exp_np;
  logic       chk_irq_rise;
  logic       chk_no_irq;
  logic       btn_byte;
  logic       dy_byte;
  logic [1:0] exp_btns;
  logic       chk_quad_done;
  logic [1:0] x_prev;
  logic [1:0] y_prev;
  int         x_fwd;
  int         x_back;
  int         y_fwd;
  int         y_back;

  `include "hid_tb_tasks.svh"

  hid_top i_hid_top (.*);

  always #10 clk = ~clk;

  // count phase steps per axis and direction
  always @(negedge clk) begin
    if (reset) begin
      x_prev = 2'b00;
      y_prev = 2'b00;
      x_fwd  = 0;
      x_back = 0;
      y_fwd  = 0;
      y_back = 0;
    end else begin
      if (mouse_x_quad != x_prev) begin
        if (mouse_x_quad == phase_fwd(x_prev)) x_fwd++;
        else x_back++;
      end
      if (mouse_y_quad != y_prev) begin
        if (mouse_y_quad == phase_fwd(y_prev)) y_fwd++;
        else y_back++;
      end
      x_prev = mouse_x_quad;
      y_prev = mouse_y_quad;
    end
  end

  dout_ok: assert property (@(posedge clk) disable iff (reset)
    chk_dout |-> data_out == exp_dout)
    else report_mismatch("data_out differs from the expected byte");

  key_ok: assert property (@(posedge clk) disable iff (reset)
    chk_key |-> matrix_in == ((key_down && !matrix_out[key_row]) ?
                              ~(8'd1 << key_col) : 8'hff))
    else report_mismatch("matrix_in wrong for the selected rows");

  joy_ok: assert property (@(posedge clk) disable iff (reset)
    chk_joy |-> joystick0 == exp_j0 && joystick1 == exp_j1 && numpad == exp_np)
    else report_mismatch("joystick or numpad register wrong");

  irq_rise_ok: assert property (@(posedge clk) disable iff (reset)
    chk_irq_rise && $changed(db9_port) |-> ##[2:3] irq)
    else report_mismatch("irq late after an armed DB9 change");

  irq_clear_ok: assert property (@(posedge clk) disable iff (reset)
    iack |=> !irq)
    else report_mismatch("irq still high after iack");

  irq_quiet_ok: assert property (@(posedge clk) disable iff (reset)
    chk_no_irq |-> !irq)
    else report_mismatch("irq high while not armed");

  btn_ok: assert property (@(posedge clk) disable iff (reset)
    data_in_strobe && btn_byte |-> ##2 mouse_btns == exp_btns)
    else report_mismatch("mouse_btns not loaded");

  strobe_ok: assert property (@(posedge clk) disable iff (reset)
    data_in_strobe && dy_byte |-> ##2 mouse_strobe ##1 !mouse_strobe)
    else report_mismatch("mouse_strobe not a single pulse after dy");

  stray_strobe_ok: assert property (@(posedge clk) disable iff (reset)
    mouse_strobe |-> $past(data_in_strobe && dy_byte, 2))
    else report_mismatch("mouse_strobe without a dy byte");

  quad_dir_ok: assert property (@(posedge clk) disable iff (reset)
    x_back == 0 && y_fwd == 0 && x_fwd <= 3 && y_back <= 2)
    else report_mismatch("quadrature step in the wrong direction or extra");

  quad_end_ok: assert property (@(posedge clk) disable iff (reset)
    chk_quad_done |-> x_fwd == 3 && y_back == 2 &&
                      mouse_x_quad == 2'b10 && mouse_y_quad == 2'b11)
    else report_mismatch("quadrature did not settle at the expected phase");

  initial begin
    logic [7:0] r;
    clk = 1'b0;
    reset = 1'b1;
    data_in_strobe = 1'b0;
    data_in_start = 1'b0;
    data_in = 8'd0;
    db9_port = 6'd0;
    iack = 1'b0;
    matrix_out = 8'hff;
    {chk_dout, chk_key, key_down, chk_joy, chk_irq_rise} = 5'b0;
    {btn_byte, dy_byte, chk_quad_done} = 3'b0;
    chk_no_irq = 1'b1;
    {exp_dout, exp_j0, exp_j1, exp_np} = 32'd0;
    {key_row, key_col, exp_btns} = 8'd0;
    lfsr = 32'h808b1ae7;
    errors = 0;
    tests = 0;
    test_base = 0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    check_dout(8'h00);
    send_byte(1'b1, hid_cmd_pkg::cmd_status);
    send_byte(1'b0, 8'h00);
    check_dout(8'h5c);
    send_byte(1'b0, 8'h00);
    check_dout(8'h42);
    end_test("status");

    chk_key = 1'b1;
    scan_matrix();
    chk_key = 1'b0;
    rand_bits(3, r);
    key_row = r[2:0];
    rand_bits(3, r);
    key_col = r[2:0];
    send_byte(1'b1, hid_cmd_pkg::cmd_keyboard);
    send_byte(1'b0, {1'b0, 1'b0, key_col, key_row});
    key_down = 1'b1;
    chk_key = 1'b1;
    scan_matrix();
    chk_key = 1'b0;
    send_byte(1'b1, hid_cmd_pkg::cmd_keyboard);
    send_byte(1'b0, {1'b1, 1'b0, key_col, key_row});
    key_down = 1'b0;
    chk_key = 1'b1;
    scan_matrix();
    chk_key = 1'b0;
    end_test("keyboard");

    chk_joy = 1'b1;
    idle(2);
    joy_packet(hid_io_pkg::dev_joy0);
    joy_packet(hid_io_pkg::dev_joy1);
    joy_packet(hid_io_pkg::dev_numpad);
    joy_packet(8'h02);
    joy_packet(8'h7f);
    chk_joy = 1'b0;
    end_test("joystick");

    // a change before arming must not fire
    rand_bits(6, r);
    db9_port = r[5:0] | 6'd1;
    idle(4);
    send_byte(1'b1, hid_cmd_pkg::cmd_db9);
    send_byte(1'b0, 8'h00);
    check_dout({2'b00, db9_port});
    chk_no_irq = 1'b0;
    chk_irq_rise = 1'b1;
    rand_bits(6, r);
    db9_port = db9_port ^ (r[5:0] | 6'd1);
    wait_irq(20);
    chk_irq_rise = 1'b0;
    iack = 1'b1;
    @(negedge clk);
    iack = 1'b0;
    @(negedge clk);
    chk_no_irq = 1'b1;
    rand_bits(6, r);
    db9_port = db9_port ^ (r[5:0] | 6'd1);
    idle(12);
    end_test("db9");

    // at least one button down so the load is visible
    rand_bits(2, r);
    exp_btns = r[1:0] | 2'b01;
    send_byte(1'b1, hid_cmd_pkg::cmd_mouse);
    btn_byte = 1'b1;
    send_byte(1'b0, {6'd0, exp_btns});
    btn_byte = 1'b0;
    send_byte(1'b0, 8'd3);
    dy_byte = 1'b1;
    send_byte(1'b0, 8'hfe);
    dy_byte = 1'b0;
    wait_quad(6 * 16384);
    // hold past several more step pulses
    idle(3 * 16384);
    chk_quad_done = 1'b1;
    idle(2);
    chk_quad_done = 1'b0;
    end_test("mouse");

    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/hid_cmd_fsm.sv */
/*
  Packet decoder for the MCU byte link. Every strobe is consumed, there is
  no back-pressure. Write pulses and pay are valid the cycle after a strobe.
  data_out must be read before the next strobe.
*/
`timescale 1ns/100ps
`default_nettype none

module hid_cmd_fsm (
  input  wire                                clk,
  input  wire                                reset,
  input  wire                                data_in_strobe,
  input  wire                                data_in_start,
  input  wire  [7:0]                         data_in,
  input  wire  [hid_io_pkg::db9_bits-1:0]    db9_port,
  output logic [7:0]                         data_out,
  output hid_cmd_pkg::payload_u              pay,
  output logic                               kbd_we,
  output logic                               btn_we,
  output logic                               dx_we,
  output logic                               dy_we,
  output logic                               dev_we,
  output logic                               joy_we,
  output logic                               arm
);

  logic [7:0] cmd;
  logic [3:0] idx;
  logic       pay_byte;
  logic [6:0] we_vec;

  // payload byte inside an open packet
  assign pay_byte = data_in_strobe && !data_in_start && (idx != 4'd0);
  assign we_vec = {kbd_we, btn_we, dx_we, dy_we, dev_we, joy_we, arm};

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd      <= hid_cmd_pkg::cmd_status;
      idx      <= 4'd0;
      data_out <= 8'd0;
      kbd_we   <= 1'b0;
      btn_we   <= 1'b0;
      dx_we    <= 1'b0;
      dy_we    <= 1'b0;
      dev_we   <= 1'b0;
      joy_we   <= 1'b0;
      arm      <= 1'b0;
    end else begin
      kbd_we <= 1'b0;
      btn_we <= 1'b0;
      dx_we  <= 1'b0;
      dy_we  <= 1'b0;
      dev_we <= 1'b0;
      joy_we <= 1'b0;
      arm    <= 1'b0;
      if (data_in_strobe && data_in_start) begin
        cmd <= data_in;
        idx <= 4'd1;
      end else if (pay_byte) begin
        if (idx != hid_cmd_pkg::byte_idx_max) begin
          idx <= idx + 4'd1;
        end
        case (cmd)
          hid_cmd_pkg::cmd_status: begin
            if (idx == 4'd1) begin
              data_out <= hid_cmd_pkg::status_id0;
            end else if (idx == 4'd2) begin
              data_out <= hid_cmd_pkg::status_id1;
            end
          end
          hid_cmd_pkg::cmd_keyboard: kbd_we <= (idx == 4'd1);
          hid_cmd_pkg::cmd_mouse: begin
            btn_we <= (idx == 4'd1);
            dx_we  <= (idx == 4'd2);
            dy_we  <= (idx == 4'd3);
          end
          hid_cmd_pkg::cmd_joystick: begin
            dev_we <= (idx == 4'd1);
            joy_we <= (idx == 4'd2);
          end
          hid_cmd_pkg::cmd_db9: begin
            // first byte (re)arms the change interrupt
            arm      <= (idx == 4'd1);
            data_out <= {{(8 - hid_io_pkg::db9_bits){1'b0}}, db9_port};
          end
          default: ;
        endcase
      end
    end
  end

  // payload travels next to its write pulse
  always_ff @(posedge clk) begin
    if (data_in_strobe) begin
      pay.raw <= data_in;
    end
  end

  we_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(we_vec));

  // no pulse while the byte index is still idle
  we_idx_open: assert property (@(posedge clk) disable iff (reset)
    (|we_vec) |-> idx != 4'd0);

endmodule

`default_nettype wire

/* verilog/hid_cmd_pkg.sv */
/*
  Command codes and payload decoding for the IO MCU byte link.
  Status bytes are fixed identification values. Real status is not reported.
*/
`default_nettype none

package hid_cmd_pkg;

  // command byte sent with data_in_start
  localparam logic [7:0] cmd_status   = 8'd0;
  localparam logic [7:0] cmd_keyboard = 8'd1;
  localparam logic [7:0] cmd_mouse    = 8'd2;
  localparam logic [7:0] cmd_joystick = 8'd3;
  localparam logic [7:0] cmd_db9      = 8'd4;

  // the byte index stops here on long packets
  localparam logic [3:0] byte_idx_max = 4'd15;

  // identification returned by the status command
  localparam logic [7:0] status_id0 = 8'h5c;
  localparam logic [7:0] status_id1 = 8'h42;

  // keyboard event byte
  typedef struct packed {
    logic       released;  // 1 when the key goes up
    logic       unused;
    logic [2:0] col;
    logic [2:0] row;
  } key_event_t;

  // one payload byte, read as a key event or as a plain value
  typedef union packed {
    key_event_t key;
    logic [7:0] raw;
  } payload_u;

endpackage

`default_nettype wire

/* verilog/hid_io_pkg.sv */
/*
  Device ids and port widths of the human-interface devices.
  The mouse divider width sets the replay rate of one step per 2^14 idle cycles.
*/
`default_nettype none

package hid_io_pkg;

  // device byte of the joystick command
  localparam logic [7:0] dev_joy0   = 8'h00;
  localparam logic [7:0] dev_joy1   = 8'h01;
  localparam logic [7:0] dev_numpad = 8'h80;

  // mouse step divider
  localparam int mouse_div_bits = 14;

  // local DB9 port, fire buttons and directions
  localparam int db9_bits = 6;

  // two phase outputs per mouse axis
  localparam int quad_bits = 2;

  // keyboard matrix rows, each a byte of columns
  localparam int matrix_rows = 8;

endpackage

`default_nettype wire

/* verilog/hid_top.sv */
/*
  Human-interface block between the IO MCU byte link and the emulated
  machine: keyboard matrix, mouse quadrature, joysticks and DB9 interrupt.
*/
`timescale 1ns/100ps
`default_nettype none

module hid_top (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire                                 data_in_strobe,
  input  wire                                 data_in_start,
  input  wire  [7:0]                          data_in,
  output wire  [7:0]                          data_out,
  input  wire  [hid_io_pkg::db9_bits-1:0]     db9_port,
  input  wire                                 iack,
  output wire                                 irq,
  output wire  [7:0]                          joystick0,
  output wire  [7:0]                          joystick1,
  output wire  [7:0]                          numpad,
  input  wire  [hid_io_pkg::matrix_rows-1:0]  matrix_out,
  output wire  [7:0]                          matrix_in,
  output wire  [1:0]                          mouse_btns,
  output wire                                 mouse_strobe,
  output wire  [hid_io_pkg::quad_bits-1:0]    mouse_x_quad,
  output wire  [hid_io_pkg::quad_bits-1:0]    mouse_y_quad
);

  hid_cmd_pkg::payload_u pay;
  wire kbd_we;
  wire btn_we;
  wire dx_we;
  wire dy_we;
  wire dev_we;
  wire joy_we;
  wire arm;
  wire step;

  hid_cmd_fsm i_hid_cmd_fsm (
    .clk            (clk),
    .reset          (reset),
    .data_in_strobe (data_in_strobe),
    .data_in_start  (data_in_start),
    .data_in        (data_in),
    .db9_port       (db9_port),
    .data_out       (data_out),
    .pay            (pay),
    .kbd_we         (kbd_we),
    .btn_we         (btn_we),
    .dx_we          (dx_we),
    .dy_we          (dy_we),
    .dev_we         (dev_we),
    .joy_we         (joy_we),
    .arm            (arm)
  );

  mouse_step_timer i_mouse_step_timer (
    .clk            (clk),
    .reset          (reset),
    .data_in_strobe (data_in_strobe),
    .step           (step)
  );

  mouse_quadrature i_mouse_quadrature (
    .clk          (clk),
    .reset        (reset),
    .pay          (pay),
    .btn_we       (btn_we),
    .dx_we        (dx_we),
    .dy_we        (dy_we),
    .step         (step),
    .mouse_btns   (mouse_btns),
    .mouse_strobe (mouse_strobe),
    .mouse_x_quad (mouse_x_quad),
    .mouse_y_quad (mouse_y_quad)
  );

  keyboard_matrix i_keyboard_matrix (
    .clk        (clk),
    .reset      (reset),
    .pay        (pay),
    .kbd_we     (kbd_we),
    .matrix_out (matrix_out),
    .matrix_in  (matrix_in)
  );

  joystick_port i_joystick_port (
    .clk       (clk),
    .reset     (reset),
    .pay       (pay),
    .dev_we    (dev_we),
    .joy_we    (joy_we),
    .arm       (arm),
    .db9_port  (db9_port),
    .iack      (iack),
    .joystick0 (joystick0),
    .joystick1 (joystick1),
    .numpad    (numpad),
    .irq       (irq)
  );

endmodule

`default_nettype wire

/* verilog/joystick_port.sv */
/*
  Digital joystick and numpad registers, plus the DB9 change interrupt.
  db9_port is synchronised first, so irq follows a change by 2 to 3 cycles.
  Unknown device ids are ignored.
*/
`timescale 1ns/100ps
`default_nettype none

module joystick_port (
  input  wire                               clk,
  input  wire                               reset,
  input  wire  hid_cmd_pkg::payload_u       pay,
  input  wire                               dev_we,
  input  wire                               joy_we,
  input  wire                               arm,
  input  wire  [hid_io_pkg::db9_bits-1:0]   db9_port,
  input  wire                               iack,
  output logic [7:0]                        joystick0,
  output logic [7:0]                        joystick1,
  output logic [7:0]                        numpad,
  output logic                              irq
);

  logic [7:0]                      device;
  logic                            armed;
  logic [hid_io_pkg::db9_bits-1:0] db9_s;
  logic [hid_io_pkg::db9_bits-1:0] db9_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      device    <= 8'hff;
      joystick0 <= 8'd0;
      joystick1 <= 8'd0;
      numpad    <= 8'd0;
    end else begin
      if (dev_we) begin
        device <= pay.raw;
      end
      if (joy_we) begin
        case (device)
          hid_io_pkg::dev_joy0:   joystick0 <= pay.raw;
          hid_io_pkg::dev_joy1:   joystick1 <= pay.raw;
          hid_io_pkg::dev_numpad: numpad    <= pay.raw;
          default: ;
        endcase
      end
    end
  end

  // port samples, compared only while armed
  always_ff @(posedge clk) begin
    db9_s <= db9_port;
    db9_d <= db9_s;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      armed <= 1'b0;
      irq   <= 1'b0;
    end else begin
      if (arm) begin
        armed <= 1'b1;
      end else if (armed && db9_s != db9_d) begin
        // one interrupt per arm
        armed <= 1'b0;
        irq   <= 1'b1;
      end
      if (iack) begin
        irq <= 1'b0;
      end
    end
  end

  irq_needs_arm: assert property (@(posedge clk) disable iff (reset)
    $rose(irq) |-> $past(armed));

endmodule

`default_nettype wire

/* verilog/keyboard_matrix.sv */
/*
  8x8 keyboard matrix. A cleared bit is a pressed key.
  The scan is combinational and active low: matrix_out selects rows,
  matrix_in returns the AND of the selected rows.
*/
`timescale 1ns/100ps
`default_nettype none

module keyboard_matrix (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire  hid_cmd_pkg::payload_u         pay,
  input  wire                                 kbd_we,
  input  wire  [hid_io_pkg::matrix_rows-1:0]  matrix_out,
  output logic [7:0]                          matrix_in
);

  logic [7:0] rows [hid_io_pkg::matrix_rows];

  always_ff @(posedge clk) begin
    if (reset) begin
      // all keys up
      for (int r = 0; r < hid_io_pkg::matrix_rows; r++) begin
        rows[r] <= 8'hff;
      end
    end else if (kbd_we) begin
      rows[pay.key.row][pay.key.col] <= pay.key.released;
    end
  end

  always_comb begin
    matrix_in = 8'hff;
    for (int r = 0; r < hid_io_pkg::matrix_rows; r++) begin
      if (!matrix_out[r]) begin
        matrix_in = matrix_in & rows[r];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/mouse_quadrature.sv */
/*
  Mouse buttons and quadrature replay. Deltas add into signed 8-bit
  accumulators and wrap on overflow. One phase step per axis per step pulse.
*/
`timescale 1ns/100ps
`default_nettype none

module mouse_quadrature (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire  hid_cmd_pkg::payload_u         pay,
  input  wire                                 btn_we,
  input  wire                                 dx_we,
  input  wire                                 dy_we,
  input  wire                                 step,
  output logic [1:0]                          mouse_btns,
  output logic                                mouse_strobe,
  output logic [hid_io_pkg::quad_bits-1:0]    mouse_x_quad,
  output logic [hid_io_pkg::quad_bits-1:0]    mouse_y_quad
);

  logic signed [7:0] x_cnt;
  logic signed [7:0] y_cnt;

  // gray phase, forward runs 00 01 11 10
  function automatic logic [1:0] phase_next(input logic [1:0] q, input logic back);
    if (back) begin
      return {~q[0], q[1]};
    end
    return {q[0], ~q[1]};
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      mouse_btns   <= 2'b00;
      mouse_strobe <= 1'b0;
      x_cnt        <= 8'sd0;
      y_cnt        <= 8'sd0;
      mouse_x_quad <= 2'b00;
      mouse_y_quad <= 2'b00;
    end else begin
      mouse_strobe <= dy_we;
      if (btn_we) begin
        mouse_btns <= pay.raw[1:0];
      end
      if (dx_we) begin
        x_cnt <= x_cnt + $signed(pay.raw);
      end else if (step && x_cnt != 8'sd0) begin
        // move one count toward zero
        x_cnt        <= x_cnt[7] ? x_cnt + 8'sd1 : x_cnt - 8'sd1;
        mouse_x_quad <= phase_next(mouse_x_quad, x_cnt[7]);
      end
      if (dy_we) begin
        y_cnt <= y_cnt + $signed(pay.raw);
      end else if (step && y_cnt != 8'sd0) begin
        y_cnt        <= y_cnt[7] ? y_cnt + 8'sd1 : y_cnt - 8'sd1;
        mouse_y_quad <= phase_next(mouse_y_quad, y_cnt[7]);
      end
    end
  end

  x_gray: assert property (@(posedge clk) disable iff (reset)
    $countones(mouse_x_quad ^ $past(mouse_x_quad)) <= 1);

  y_gray: assert property (@(posedge clk) disable iff (reset)
    $countones(mouse_y_quad ^ $past(mouse_y_quad)) <= 1);

endmodule

`default_nettype wire

/* verilog/mouse_step_timer.sv */
/*
  Step divider for mouse replay. The count holds during link strobes,
  so the step period is at least 2^mouse_div_bits cycles.
*/
`timescale 1ns/100ps
`default_nettype none

module mouse_step_timer (
  input  wire  clk,
  input  wire  reset,
  input  wire  data_in_strobe,
  output logic step
);

  logic [hid_io_pkg::mouse_div_bits-1:0] div;

  always_ff @(posedge clk) begin
    if (reset) begin
      div  <= '0;
      step <= 1'b0;
    end else begin
      step <= 1'b0;
      if (!data_in_strobe) begin
        div <= div + 1'b1;
        // high in the cycle where the count reads zero again
        step <= &div;
      end
    end
  end

endmodule

`default_nettype wire
